// ==== Bender.yml ====
package:
  name: cache_way

sources:
  - cache_pkg.sv
  - cache_ifs.sv
  - cache_tag_store.sv
  - cache_data_ram.sv
  - cache_way_ctrl.sv
  - cache_maint_regs.sv
  - cache_top.sv
  - target: test
    files:
      - tb_cache_mem.sv
      - tb_cache_top.sv

// ==== cache_data_ram.sv ====
/* line data RAM, 256 words, registered read and byte enabled write */
`default_nettype none
`timescale 1ns/10ps

module cache_data_ram
	import cache_pkg::*;
(
	input  logic      clk,
	cache_data_if.ram data
);

	word_t mem [NR_LINES*LINE_WORDS];

	always_ff @(posedge clk) begin
		if (data.wr_en) begin
			for (int b = 0; b < $bits(be_t); b++) begin
				if (data.wr_be[b]) begin
					mem[data.wr_addr][8*b +: 8] <= data.wr_data[8*b +: 8];
				end
			end
		end
		data.rd_data <= mem[data.rd_addr];
	end

endmodule

`default_nettype wire

// ==== cache_ifs.sv ====
/* line maintenance interface, tag store interface and data RAM interface */
`default_nettype none
`timescale 1ns/10ps

// four-phase line request from the maintenance block, plus the enable level
interface cache_line_op_if
	import cache_pkg::*;
();
	logic   op_req;
	logic   op_flush;
	index_t op_index;
	logic   enabled;
	logic   op_ack;

	modport regs (output op_req, output op_flush, output op_index, output enabled,
		input op_ack);
	modport ctrl (input op_req, input op_flush, input op_index, input enabled,
		output op_ack);
endinterface

// read data returns one cycle after rd_index
interface cache_tag_if
	import cache_pkg::*;
();
	index_t rd_index;
	tag_t   rd_tag;
	logic   rd_valid;
	logic   rd_dirty;
	logic   wr_en;
	index_t wr_index;
	tag_t   wr_tag;
	logic   wr_valid;
	logic   wr_dirty;

	modport ctrl (output rd_index, input rd_tag, input rd_valid, input rd_dirty,
		output wr_en, output wr_index, output wr_tag, output wr_valid, output wr_dirty);
	modport store (input rd_index, output rd_tag, output rd_valid, output rd_dirty,
		input wr_en, input wr_index, input wr_tag, input wr_valid, input wr_dirty);
endinterface

interface cache_data_if
	import cache_pkg::*;
();
	ram_addr_t rd_addr;
	word_t     rd_data;
	logic      wr_en;
	ram_addr_t wr_addr;
	word_t     wr_data;
	be_t       wr_be;

	modport ctrl (output rd_addr, input rd_data, output wr_en, output wr_addr,
		output wr_data, output wr_be);
	modport ram (input rd_addr, output rd_data, input wr_en, input wr_addr,
		input wr_data, input wr_be);
endinterface

`default_nettype wire

// ==== cache_maint_regs.sv ====
/* cache enable register and maintenance command sequencer */
`default_nettype none
`timescale 1ns/10ps

module cache_maint_regs
	import cache_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,
	input  logic          maint_req,
	input  maint_op_e     maint_op,
	input  index_t        maint_index,
	output logic          maint_ack,
	cache_line_op_if.regs line
);

	logic   enabled_q;
	logic   busy;
	logic   all_lines;
	logic   op_req_q;
	logic   op_flush_q;
	index_t idx;

	assign line.enabled  = enabled_q;
	assign line.op_req   = op_req_q;
	assign line.op_flush = op_flush_q;
	assign line.op_index = idx;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			enabled_q  <= 1'b0;
			busy       <= 1'b0;
			all_lines  <= 1'b0;
			op_req_q   <= 1'b0;
			op_flush_q <= 1'b0;
			idx        <= '0;
			maint_ack  <= 1'b0;
		end else if (maint_ack) begin
			if (!maint_req) begin
				maint_ack <= 1'b0;
			end
		end else if (busy) begin
			// drop the line request on ack and start the next line once ack is low
			if (op_req_q) begin
				if (line.op_ack) begin
					op_req_q <= 1'b0;
				end
			end else if (!line.op_ack) begin
				if (all_lines && idx != index_t'(NR_LINES - 1)) begin
					idx      <= idx + 1'b1;
					op_req_q <= 1'b1;
				end else begin
					busy      <= 1'b0;
					maint_ack <= 1'b1;
				end
			end
		end else if (maint_req) begin
			case (maint_op)
			MAINT_ENABLE: begin
				enabled_q <= 1'b1;
				maint_ack <= 1'b1;
			end
			MAINT_DISABLE: begin
				enabled_q <= 1'b0;
				maint_ack <= 1'b1;
			end
			MAINT_INVAL_LINE, MAINT_FLUSH_LINE: begin
				busy       <= 1'b1;
				all_lines  <= 1'b0;
				idx        <= maint_index;
				op_flush_q <= (maint_op == MAINT_FLUSH_LINE);
				op_req_q   <= 1'b1;
			end
			MAINT_INVAL_ALL, MAINT_FLUSH_ALL: begin
				busy       <= 1'b1;
				all_lines  <= 1'b1;
				idx        <= '0;
				op_flush_q <= (maint_op == MAINT_FLUSH_ALL);
				op_req_q   <= 1'b1;
			end
			// unknown opcode is acked with no effect
			default: maint_ack <= 1'b1;
			endcase
		end
	end

	a_maint_op_stable: assert property (@(posedge clk) disable iff (!arst_n)
		maint_req && !maint_ack |=> maint_ack || (maint_req && $stable(maint_op)));

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
/* cache geometry, data and address types, controller states and maintenance opcodes */
`default_nettype none

package cache_pkg;

	// word addressed, 32 lines of 8 words, direct mapped
	localparam int ADDR_W     = 30;
	localparam int LINE_WORDS = 8;
	localparam int OFFSET_W   = 3;
	localparam int NR_LINES   = 32;
	localparam int INDEX_W    = 5;
	localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [31:0]                  word_t;
	typedef logic [3:0]                   be_t;
	typedef logic [ADDR_W-1:0]            waddr_t;
	typedef logic [TAG_W-1:0]             tag_t;
	typedef logic [INDEX_W-1:0]           index_t;
	typedef logic [OFFSET_W-1:0]          offset_t;
	// word address inside the data RAM, {index, offset}
	typedef logic [INDEX_W+OFFSET_W-1:0]  ram_addr_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_EVICT,
		ST_FILL,
		ST_BYPASS,
		ST_MAINT,
		ST_DONE
	} cache_state_e;

	typedef enum logic [2:0] {
		MAINT_INVAL_LINE = 3'd0,
		MAINT_FLUSH_LINE = 3'd1,
		MAINT_INVAL_ALL  = 3'd2,
		MAINT_FLUSH_ALL  = 3'd3,
		MAINT_ENABLE     = 3'd4,
		MAINT_DISABLE    = 3'd5
	} maint_op_e;

endpackage

`default_nettype wire

// ==== cache_tag_store.sv ====
/* tag array with flop based valid and dirty bits, registered read */
`default_nettype none
`timescale 1ns/10ps

module cache_tag_store
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	cache_tag_if.store tag
);

	tag_t                tag_mem [NR_LINES];
	logic [NR_LINES-1:0] valid_q;
	logic [NR_LINES-1:0] dirty_q;

	// tags need no reset, a clear valid bit hides them
	always_ff @(posedge clk) begin
		if (tag.wr_en) begin
			tag_mem[tag.wr_index] <= tag.wr_tag;
		end
		tag.rd_tag <= tag_mem[tag.rd_index];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q      <= '0;
			dirty_q      <= '0;
			tag.rd_valid <= 1'b0;
			tag.rd_dirty <= 1'b0;
		end else begin
			if (tag.wr_en) begin
				valid_q[tag.wr_index] <= tag.wr_valid;
				dirty_q[tag.wr_index] <= tag.wr_dirty;
			end
			// read returns the old state on a same-cycle write
			tag.rd_valid <= valid_q[tag.rd_index];
			tag.rd_dirty <= dirty_q[tag.rd_index];
		end
	end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
/* cache top level with plain CPU, memory and maintenance ports */
`default_nettype none
`timescale 1ns/10ps

module cache_top
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	// cpu port
	input  logic      cpu_req,
	input  logic      cpu_we,
	input  waddr_t    cpu_addr,
	input  word_t     cpu_wdata,
	input  be_t       cpu_be,
	output word_t     cpu_rdata,
	output logic      cpu_ack,
	// memory port
	output logic      mem_req,
	output logic      mem_we,
	output waddr_t    mem_addr,
	output word_t     mem_wdata,
	output be_t       mem_be,
	input  word_t     mem_rdata,
	input  logic      mem_ack,
	// maintenance port
	input  logic      maint_req,
	input  maint_op_e maint_op,
	input  index_t    maint_index,
	output logic      maint_ack
);

	cache_line_op_if line_if ();
	cache_tag_if     tag_if ();
	cache_data_if    data_if ();

	cache_maint_regs maint_regs_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.maint_req   (maint_req),
		.maint_op    (maint_op),
		.maint_index (maint_index),
		.maint_ack   (maint_ack),
		.line        (line_if.regs)
	);

	cache_way_ctrl way_ctrl_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.cpu_req   (cpu_req),
		.cpu_we    (cpu_we),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_be    (cpu_be),
		.cpu_rdata (cpu_rdata),
		.cpu_ack   (cpu_ack),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_be    (mem_be),
		.mem_rdata (mem_rdata),
		.mem_ack   (mem_ack),
		.line      (line_if.ctrl),
		.tag       (tag_if.ctrl),
		.data      (data_if.ctrl)
	);

	cache_tag_store tag_store_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.tag    (tag_if.store)
	);

	cache_data_ram data_ram_inst (
		.clk  (clk),
		.data (data_if.ram)
	);

endmodule

`default_nettype wire

// ==== cache_way_ctrl.sv ====
/* cache way controller: lookup, write-back, line fill, bypass and line maintenance */
`default_nettype none
`timescale 1ns/10ps

module cache_way_ctrl
	import cache_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,
	input  logic          cpu_req,
	input  logic          cpu_we,
	input  waddr_t        cpu_addr,
	input  word_t         cpu_wdata,
	input  be_t           cpu_be,
	output word_t         cpu_rdata,
	output logic          cpu_ack,
	output logic          mem_req,
	output logic          mem_we,
	output waddr_t        mem_addr,
	output word_t         mem_wdata,
	output be_t           mem_be,
	input  word_t         mem_rdata,
	input  logic          mem_ack,
	cache_line_op_if.ctrl line,
	cache_tag_if.ctrl     tag,
	cache_data_if.ctrl    data
);

	cache_state_e state;

	waddr_t  lat_addr;
	logic    lat_we;
	word_t   lat_wdata;
	be_t     lat_be;
	logic    lat_flush;
	logic    lat_maint;
	offset_t cnt;
	logic    lk_cmp;
	logic    mem_arm;
	logic    mem_rel;
	logic    op_ack_q;

	tag_t    lat_tag;
	index_t  lat_index;
	offset_t lat_offset;
	logic    hit;
	logic    victim_dirty;
	logic    last_word;
	logic    mem_take;
	logic    word_done;

	assign lat_tag    = lat_addr[ADDR_W-1 -: TAG_W];
	assign lat_index  = lat_addr[OFFSET_W +: INDEX_W];
	assign lat_offset = lat_addr[OFFSET_W-1:0];

	assign hit          = tag.rd_valid && (tag.rd_tag == lat_tag);
	assign victim_dirty = tag.rd_valid && tag.rd_dirty;
	assign last_word    = (cnt == offset_t'(LINE_WORDS - 1));
	assign mem_take     = mem_req && mem_ack;
	// memory handshake closed once ack is back low
	assign word_done    = mem_rel && !mem_ack;

	assign line.op_ack  = op_ack_q;
	assign tag.rd_index = lat_index;
	assign data.rd_addr = {lat_index, (state == ST_LOOKUP) ? lat_offset : cnt};

	// store writes for a write hit, the last fill word and invalidation
	always_comb begin
		tag.wr_en     = 1'b0;
		tag.wr_index  = lat_index;
		tag.wr_tag    = lat_tag;
		tag.wr_valid  = 1'b1;
		tag.wr_dirty  = 1'b0;
		data.wr_en    = 1'b0;
		data.wr_addr  = {lat_index, cnt};
		data.wr_data  = mem_rdata;
		data.wr_be    = '1;
		case (state)
		ST_LOOKUP: begin
			if (lk_cmp && hit && lat_we) begin
				tag.wr_en    = 1'b1;
				tag.wr_dirty = 1'b1;
				data.wr_en   = 1'b1;
				data.wr_addr = {lat_index, lat_offset};
				data.wr_data = lat_wdata;
				data.wr_be   = lat_be;
			end
		end
		ST_FILL: begin
			data.wr_en = mem_take;
			tag.wr_en  = mem_take && last_word;
		end
		ST_EVICT: begin
			if (word_done && last_word && lat_maint) begin
				tag.wr_en    = 1'b1;
				tag.wr_tag   = tag.rd_tag;
				tag.wr_valid = 1'b0;
			end
		end
		ST_MAINT: begin
			if (lk_cmp && !(lat_flush && victim_dirty)) begin
				tag.wr_en    = 1'b1;
				tag.wr_tag   = tag.rd_tag;
				tag.wr_valid = 1'b0;
			end
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			lat_maint <= 1'b0;
			lk_cmp    <= 1'b0;
			cnt       <= '0;
			mem_req   <= 1'b0;
			mem_arm   <= 1'b0;
			mem_rel   <= 1'b0;
			cpu_ack   <= 1'b0;
			op_ack_q  <= 1'b0;
		end else begin
			case (state)
			ST_IDLE: begin
				// cpu wins over a pending maintenance request
				if (cpu_req) begin
					lat_maint <= 1'b0;
					state     <= line.enabled ? ST_LOOKUP : ST_BYPASS;
				end else if (line.op_req) begin
					lat_maint <= 1'b1;
					state     <= ST_MAINT;
				end
			end
			ST_LOOKUP: begin
				// first cycle addresses the stores and the second compares
				lk_cmp <= !lk_cmp;
				if (lk_cmp) begin
					if (hit) begin
						cpu_ack <= 1'b1;
						state   <= ST_DONE;
					end else if (lat_we) begin
						state <= ST_BYPASS;
					end else if (victim_dirty) begin
						state <= ST_EVICT;
					end else begin
						state <= ST_FILL;
					end
				end
			end
			ST_MAINT: begin
				lk_cmp <= !lk_cmp;
				if (lk_cmp) begin
					if (lat_flush && victim_dirty) begin
						state <= ST_EVICT;
					end else begin
						op_ack_q <= 1'b1;
						state    <= ST_DONE;
					end
				end
			end
			ST_EVICT, ST_FILL, ST_BYPASS: begin
				// one word per handshake with an arm cycle for the RAM read
				if (mem_req) begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						mem_rel <= 1'b1;
					end
				end else if (mem_rel) begin
					if (!mem_ack) begin
						mem_rel <= 1'b0;
					end
				end else if (mem_arm) begin
					mem_arm <= 1'b0;
					mem_req <= 1'b1;
				end else begin
					mem_arm <= 1'b1;
				end

				if (word_done) begin
					if (state == ST_BYPASS) begin
						cpu_ack <= 1'b1;
						state   <= ST_DONE;
					end else if (!last_word) begin
						cnt <= cnt + 1'b1;
					end else begin
						cnt <= '0;
						if (state == ST_FILL) begin
							cpu_ack <= 1'b1;
							state   <= ST_DONE;
						end else if (lat_maint) begin
							op_ack_q <= 1'b1;
							state    <= ST_DONE;
						end else begin
							state <= ST_FILL;
						end
					end
				end
			end
			ST_DONE: begin
				if (lat_maint ? !line.op_req : !cpu_req) begin
					cpu_ack  <= 1'b0;
					op_ack_q <= 1'b0;
					state    <= ST_IDLE;
				end
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

	// request payload and memory word registers
	always_ff @(posedge clk) begin
		if (state == ST_IDLE) begin
			if (cpu_req) begin
				lat_addr  <= cpu_addr;
				lat_we    <= cpu_we;
				lat_wdata <= cpu_wdata;
				lat_be    <= cpu_be;
			end else if (line.op_req) begin
				lat_addr  <= {{TAG_W{1'b0}}, line.op_index, {OFFSET_W{1'b0}}};
				lat_flush <= line.op_flush;
			end
		end

		if (mem_arm) begin
			mem_we    <= 1'b0;
			mem_wdata <= data.rd_data;
			mem_be    <= '1;
			case (state)
			ST_EVICT: begin
				mem_we   <= 1'b1;
				mem_addr <= {tag.rd_tag, lat_index, cnt};
			end
			ST_FILL: mem_addr <= {lat_tag, lat_index, cnt};
			default: begin
				mem_we    <= lat_we;
				mem_addr  <= lat_addr;
				mem_wdata <= lat_wdata;
				if (lat_we) begin
					mem_be <= lat_be;
				end
			end
			endcase
		end

		if (state == ST_LOOKUP && lk_cmp && hit) begin
			cpu_rdata <= data.rd_data;
		end else if (mem_take && state == ST_BYPASS) begin
			cpu_rdata <= mem_rdata;
		end else if (mem_take && state == ST_FILL && cnt == lat_offset) begin
			cpu_rdata <= mem_rdata;
		end
	end

	a_mem_hold: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr));

	a_cpu_ack_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(cpu_ack) |-> $past(cpu_req));

endmodule

`default_nettype wire

// ==== tb_cache_mem.sv ====
/* testbench memory responder: 4096 word array, four-phase replies with random delay,
   read and write request counters */
`default_nettype none
`timescale 1ns/10ps

module tb_cache_mem
	import cache_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   mem_req,
	input  logic   mem_we,
	input  waddr_t mem_addr,
	input  word_t  mem_wdata,
	input  be_t    mem_be,
	output word_t  mem_rdata,
	output logic   mem_ack
);

	word_t       mem [4096];
	int          rd_count;
	int          wr_count;
	logic [31:0] lfsr;
	logic [31:0] step1;
	logic [31:0] step2;
	logic [1:0]  delay;
	logic [1:0]  wait_cnt;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// every word holds a pattern made from its whole index
	initial begin
		for (int i = 0; i < 4096; i++) begin
			mem[i] = {i[11:0], 8'h5a, ~i[11:0]};
		end
	end

	// replies change on the falling edge, away from the DUT sampling edge
	always @(negedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_ack   <= 1'b0;
			mem_rdata <= '0;
			wait_cnt  <= '0;
			delay     <= '0;
			lfsr      <= 32'hf6ee_200e;
			rd_count  <= 0;
			wr_count  <= 0;
		end else if (mem_req && !mem_ack) begin
			if (wait_cnt == delay) begin
				if (mem_we) begin
					for (int b = 0; b < 4; b++) begin
						if (mem_be[b]) begin
							mem[mem_addr[11:0]][8*b +: 8] <= mem_wdata[8*b +: 8];
						end
					end
					wr_count <= wr_count + 1;
				end else begin
					mem_rdata <= mem[mem_addr[11:0]];
					rd_count  <= rd_count + 1;
				end
				mem_ack  <= 1'b1;
				wait_cnt <= '0;
				// two bits of delay, one step each
				step1 = lfsr_next(lfsr);
				step2 = lfsr_next(step1);
				delay <= {lfsr[0], step1[0]};
				lfsr  <= step2;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end else if (mem_ack && !mem_req) begin
			mem_ack <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== tb_cache_top.sv ====
/* cache testbench: clock, reset, LFSR stimulus, reference model of memory and cache,
   compare tasks and pass/fail reporting */
`default_nettype none
`timescale 1ns/10ps

module tb_cache_top
	import cache_pkg::*;
();

	logic      clk;
	logic      arst_n;
	logic      cpu_req;
	logic      cpu_we;
	waddr_t    cpu_addr;
	word_t     cpu_wdata;
	be_t       cpu_be;
	word_t     cpu_rdata;
	logic      cpu_ack;
	logic      mem_req;
	logic      mem_we;
	waddr_t    mem_addr;
	word_t     mem_wdata;
	be_t       mem_be;
	word_t     mem_rdata;
	logic      mem_ack;
	logic      maint_req;
	maint_op_e maint_op;
	index_t    maint_index;
	logic      maint_ack;

	logic [31:0] lfsr;

	// model: expected memory array plus a shadow of the cache way
	word_t bk_mem [4096];
	word_t sh_data [NR_LINES*LINE_WORDS];
	tag_t  sh_tag [NR_LINES];
	logic  sh_valid [NR_LINES];
	logic  sh_dirty [NR_LINES];
	logic  cache_on;

	cache_top cache_top_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.cpu_req     (cpu_req),
		.cpu_we      (cpu_we),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_be      (cpu_be),
		.cpu_rdata   (cpu_rdata),
		.cpu_ack     (cpu_ack),
		.mem_req     (mem_req),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_be      (mem_be),
		.mem_rdata   (mem_rdata),
		.mem_ack     (mem_ack),
		.maint_req   (maint_req),
		.maint_op    (maint_op),
		.maint_index (maint_index),
		.maint_ack   (maint_ack)
	);

	tb_cache_mem mem_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_be    (mem_be),
		.mem_rdata (mem_rdata),
		.mem_ack   (mem_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic waddr_t make_addr(input int tg, input int ix, input int off);
		return {tag_t'(tg), index_t'(ix), offset_t'(off)};
	endfunction

	// four tags over four indexes, so lines keep colliding
	function automatic waddr_t rand_addr();
		logic [31:0] tg;
		logic [31:0] ix;
		logic [31:0] off;
		tg  = rand_bits(2);
		ix  = rand_bits(2);
		off = rand_bits(3);
		return make_addr(int'(tg), int'(ix), int'(off));
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t wd, input be_t be);
		word_t r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				r[8*b +: 8] = wd[8*b +: 8];
			end
		end
		return r;
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			fail_run($sformatf("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_mem(input waddr_t a, input word_t exp);
		word_t got;
		got = mem_inst.mem[a[11:0]];
		if (got !== exp) begin
			fail_run($sformatf("** Error at %0t: mem[%h] is %h, expected %h",
				$time, a, got, exp));
		end
	endtask

	task automatic write_back(input index_t idx);
		waddr_t a;
		for (int k = 0; k < LINE_WORDS; k++) begin
			a = {sh_tag[idx], idx, offset_t'(k)};
			bk_mem[a[11:0]] = sh_data[int'(idx)*LINE_WORDS + k];
		end
	endtask

	task automatic drop_line(input index_t idx, input logic flush, inout int nw);
		if (flush && sh_valid[idx] && sh_dirty[idx]) begin
			write_back(idx);
			nw = nw + LINE_WORDS;
		end
		sh_valid[idx] = 1'b0;
		sh_dirty[idx] = 1'b0;
	endtask

	// predicts read data, hit and memory request counts, and updates the model
	task automatic predict(input logic we, input waddr_t a, input word_t wd, input be_t be,
		output word_t rd, output logic hit, output int nr, output int nw);
		index_t idx;
		tag_t   tg;
		int     w;
		waddr_t fa;
		idx = a[OFFSET_W +: INDEX_W];
		tg  = a[ADDR_W-1 -: TAG_W];
		w   = int'(a[OFFSET_W+INDEX_W-1:0]);
		rd  = '0;
		hit = 1'b0;
		nr  = 0;
		nw  = 0;
		if (!cache_on) begin
			if (we) begin
				bk_mem[a[11:0]] = merge_bytes(bk_mem[a[11:0]], wd, be);
				nw = 1;
			end else begin
				rd = bk_mem[a[11:0]];
				nr = 1;
			end
		end else begin
			hit = sh_valid[idx] && (sh_tag[idx] == tg);
			if (hit) begin
				if (we) begin
					sh_data[w]    = merge_bytes(sh_data[w], wd, be);
					sh_dirty[idx] = 1'b1;
				end else begin
					rd = sh_data[w];
				end
			end else if (we) begin
				// write miss goes around the cache
				bk_mem[a[11:0]] = merge_bytes(bk_mem[a[11:0]], wd, be);
				nw = 1;
			end else begin
				drop_line(idx, 1'b1, nw);
				for (int k = 0; k < LINE_WORDS; k++) begin
					fa = {tg, idx, offset_t'(k)};
					sh_data[int'(idx)*LINE_WORDS + k] = bk_mem[fa[11:0]];
				end
				sh_tag[idx]   = tg;
				sh_valid[idx] = 1'b1;
				nr = LINE_WORDS;
				rd = sh_data[w];
			end
		end
	endtask

	task automatic model_maint(input maint_op_e op, input index_t idx, output int nw);
		nw = 0;
		case (op)
		MAINT_ENABLE:     cache_on = 1'b1;
		MAINT_DISABLE:    cache_on = 1'b0;
		MAINT_INVAL_LINE: drop_line(idx, 1'b0, nw);
		MAINT_FLUSH_LINE: drop_line(idx, 1'b1, nw);
		MAINT_INVAL_ALL, MAINT_FLUSH_ALL: begin
			for (int i = 0; i < NR_LINES; i++) begin
				drop_line(index_t'(i), op == MAINT_FLUSH_ALL, nw);
			end
		end
		default: ;
		endcase
	endtask

	// one CPU handshake; lat counts cycles from the first sampling edge to cpu_ack
	task automatic cpu_access(input logic we, input waddr_t a, input word_t wd, input be_t be,
		output word_t rd, output int lat, output int nr, output int nw);
		int r0;
		int w0;
		int n;
		@(negedge clk);
		r0        = mem_inst.rd_count;
		w0        = mem_inst.wr_count;
		cpu_we    = we;
		cpu_addr  = a;
		cpu_wdata = wd;
		cpu_be    = be;
		cpu_req   = 1'b1;
		lat = 0;
		@(negedge clk);
		while (!cpu_ack) begin
			lat++;
			if (lat > 5000) begin
				fail_run("timeout: cpu_ack did not rise for a CPU request");
			end
			@(negedge clk);
		end
		rd      = cpu_rdata;
		cpu_req = 1'b0;
		n = 0;
		while (cpu_ack) begin
			@(negedge clk);
			n++;
			if (cpu_ack && n > 100) begin
				fail_run("timeout: cpu_ack stayed high after cpu_req fell");
			end
		end
		nr = mem_inst.rd_count - r0;
		nw = mem_inst.wr_count - w0;
	endtask

	task automatic maint_cmd(input maint_op_e op, input index_t idx,
		output int nr, output int nw);
		int r0;
		int w0;
		int n;
		@(negedge clk);
		r0          = mem_inst.rd_count;
		w0          = mem_inst.wr_count;
		maint_op    = op;
		maint_index = idx;
		maint_req   = 1'b1;
		n = 0;
		@(negedge clk);
		while (!maint_ack) begin
			n++;
			if (n > 50000) begin
				fail_run("timeout: maint_ack did not rise for a maintenance command");
			end
			@(negedge clk);
		end
		maint_req = 1'b0;
		n = 0;
		while (maint_ack) begin
			@(negedge clk);
			n++;
			if (maint_ack && n > 100) begin
				fail_run("timeout: maint_ack stayed high after maint_req fell");
			end
		end
		nr = mem_inst.rd_count - r0;
		nw = mem_inst.wr_count - w0;
	endtask

	task automatic run_access(input logic we, input waddr_t a, input word_t wd, input be_t be,
		output word_t rd);
		word_t exp_rd;
		logic  hit;
		int    enr;
		int    enw;
		int    lat;
		int    nr;
		int    nw;
		predict(we, a, wd, be, exp_rd, hit, enr, enw);
		cpu_access(we, a, wd, be, rd, lat, nr, nw);
		if (!we) begin
			check_word("cpu_rdata", rd, exp_rd);
		end
		check_count("memory reads", nr, enr);
		check_count("memory writes", nw, enw);
		if (hit) begin
			check_count("hit latency", lat, 2);
		end
	endtask

	task automatic run_maint(input maint_op_e op, input index_t idx);
		int enw;
		int nr;
		int nw;
		model_maint(op, idx, enw);
		maint_cmd(op, idx, nr, nw);
		check_count("maintenance memory reads", nr, 0);
		check_count("maintenance memory writes", nw, enw);
	endtask

	initial begin
		word_t       rd;
		word_t       old;
		logic [31:0] r;
		waddr_t      a;
		word_t       wd;
		be_t         be;
		lfsr        = 32'hf6ee_200e;
		cache_on    = 1'b0;
		arst_n      = 1'b0;
		cpu_req     = 1'b0;
		cpu_we      = 1'b0;
		cpu_addr    = '0;
		cpu_wdata   = '0;
		cpu_be      = '0;
		maint_req   = 1'b0;
		maint_op    = MAINT_ENABLE;
		maint_index = '0;
		for (int i = 0; i < NR_LINES; i++) begin
			sh_valid[i] = 1'b0;
			sh_dirty[i] = 1'b0;
			sh_tag[i]   = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < 4096; i++) begin
			bk_mem[i] = mem_inst.mem[i];
		end

		// random reads with the cache on
		run_maint(MAINT_ENABLE, '0);
		repeat (60) begin
			a = rand_addr();
			run_access(1'b0, a, '0, '0, rd);
		end

		// random writes and reads, byte enables random too
		repeat (150) begin
			r  = rand_bits(1);
			a  = rand_addr();
			wd = rand_bits(32);
			be = be_t'(rand_bits(4));
			run_access(r[0], a, wd, be, rd);
		end

		// line 5: miss, read hit, write hit, then a dirty eviction
		run_access(1'b0, make_addr(1, 5, 2), '0, '0, rd);
		run_access(1'b0, make_addr(1, 5, 2), '0, '0, rd);
		run_access(1'b1, make_addr(1, 5, 6), 32'hdead_beef, 4'b1111, rd);
		run_access(1'b0, make_addr(2, 5, 6), '0, '0, rd);
		// write miss must leave line 6 unallocated, so the read misses
		run_access(1'b1, make_addr(3, 6, 1), 32'h1234_5678, 4'b0110, rd);
		run_access(1'b0, make_addr(3, 6, 1), '0, '0, rd);

		// invalidate after a write hit loses the written data
		a = make_addr(1, 7, 4);
		run_access(1'b0, a, '0, '0, rd);
		old = bk_mem[a[11:0]];
		run_access(1'b1, a, 32'hcafe_f00d, 4'b1111, rd);
		run_maint(MAINT_INVAL_LINE, index_t'(7));
		run_access(1'b0, a, '0, '0, rd);
		check_word("cpu_rdata after invalidate", rd, old);

		// more dirty lines, then flush everything and compare memory
		repeat (40) begin
			a  = rand_addr();
			wd = rand_bits(32);
			run_access(1'b1, a, wd, 4'b1111, rd);
		end
		run_maint(MAINT_FLUSH_ALL, '0);
		for (int i = 0; i < 4096; i++) begin
			check_mem(waddr_t'(i), bk_mem[i]);
		end

		// cache off: every access goes to memory once
		run_maint(MAINT_DISABLE, '0);
		repeat (40) begin
			r  = rand_bits(1);
			a  = rand_addr();
			wd = rand_bits(32);
			be = be_t'(rand_bits(4));
			run_access(r[0], a, wd, be, rd);
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
cache_pkg.sv
cache_ifs.sv
cache_tag_store.sv
cache_data_ram.sv
cache_way_ctrl.sv
cache_maint_regs.sv
cache_top.sv
tb_cache_mem.sv
tb_cache_top.sv
